/* include/cpu_params.svh */
// core-wide constants of the MIPS bus CPU
// reset vector, datapath width and register file geometry

`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// first instruction fetched after reset
`define CPU_RESET_VECTOR 32'hBFC00000

// data and address width
`define CPU_WORD_W 32

// general purpose registers, r0 reads as zero
`define CPU_REG_COUNT 32

// result register watched from outside
`define CPU_REG_V0 2

`endif

/* hw/mips_cpu_pkg.sv */
// shared types of the MIPS bus CPU
// opcodes, function codes, ALU operations, access sizes, bus states

`default_nettype none

package mips_cpu_pkg;
	`include "cpu_params.svh"

	typedef logic [`CPU_WORD_W-1:0] word_t;
	typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_addr_t;

	// primary opcodes of the supported subset
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_ANDI    = 6'h0C,
		OP_ORI     = 6'h0D,
		OP_LUI     = 6'h0F,
		OP_LB      = 6'h20,
		OP_LH      = 6'h21,
		OP_LW      = 6'h23,
		OP_LBU     = 6'h24,
		OP_LHU     = 6'h25,
		OP_SB      = 6'h28,
		OP_SH      = 6'h29,
		OP_SW      = 6'h2B
	} opcode_t;

	// function field of SPECIAL instructions
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_JR   = 6'h08,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_SLT  = 6'h2A
	} funct_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_LUI
	} alu_op_t;

	typedef enum logic [1:0] {
		SIZE_BYTE,
		SIZE_HALF,
		SIZE_WORD
	} access_size_t;

	// instruction fetch, decode/execute, memory access, stopped
	typedef enum logic [1:0] {
		ST_FETCH,
		ST_EXECUTE,
		ST_DATA,
		ST_HALTED
	} bus_state_t;

endpackage

`default_nettype wire

/* hw/bus_sequencer.sv */
// bus sequencer: fetch / execute / data FSM
// instruction register, address select and per-instruction commit pulse

`timescale 1ns/1ps
`default_nettype none

module bus_sequencer
	import mips_cpu_pkg::*;
(
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic waitrequest,
	input  word_t     readdata,
	input  word_t     pc,
	input  word_t     alu_result,
	input  wire logic mem_read,
	input  wire logic mem_write,
	input  wire logic halted,
	output word_t     instr,
	output logic      read,
	output logic      write,
	output word_t     address,
	output logic      data_phase,
	output logic      commit
);

	bus_state_t state;
	bus_state_t state_next;
	logic       mem_access;
	word_t      addr_sel;

	assign mem_access = mem_read | mem_write;

	always_comb begin
		state_next = state;
		case (state)
			ST_FETCH: begin
				// nothing is issued once pc reaches zero
				if (halted) begin
					state_next = ST_HALTED;
				end else if (!waitrequest) begin
					state_next = ST_EXECUTE;
				end
			end
			ST_EXECUTE: begin
				state_next = mem_access ? ST_DATA : ST_FETCH;
			end
			ST_DATA: begin
				if (!waitrequest) begin
					state_next = ST_FETCH;
				end
			end
			default: begin
				state_next = ST_HALTED;
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= ST_FETCH;
			instr <= '0;
		end else begin
			state <= state_next;
			// capture on the completing fetch cycle
			if (state == ST_FETCH && !halted && !waitrequest) begin
				instr <= readdata;
			end
		end
	end

	assign data_phase = (state == ST_DATA);

	assign read  = (state == ST_FETCH && !halted) || (data_phase && mem_read);
	assign write = data_phase && mem_write;

	// word aligned, data address only during the data phase
	assign addr_sel = data_phase ? alu_result : pc;
	assign address  = {addr_sel[$bits(word_t)-1:2], 2'b00};

	// end of instruction: straight after execute, or when the data transfer completes
	assign commit = (state == ST_EXECUTE && !mem_access) || (data_phase && !waitrequest);

endmodule

`default_nettype wire

/* hw/byte_lane_unit.sv */
// byte lane logic for sub-word loads and stores
// byte enables, store data replication, load extraction and extension

`timescale 1ns/1ps
`default_nettype none

module byte_lane_unit
	import mips_cpu_pkg::*;
(
	input  wire logic   data_phase,
	input  wire logic   mem_write,
	input  access_size_t access_size,
	input  wire logic   load_unsigned,
	input  wire logic [1:0] byte_offset,
	input  word_t       rt_data,
	input  word_t       readdata,
	output logic [3:0]  byteenable,
	output word_t       writedata,
	output word_t       load_data
);

	logic [7:0]  load_byte;
	logic [15:0] load_half;
	word_t       store_word;

	// lane enables
	always_comb begin
		byteenable = 4'b1111;
		if (data_phase) begin
			case (access_size)
				SIZE_BYTE: byteenable = 4'b0001 << byte_offset;
				SIZE_HALF: byteenable = byte_offset[1] ? 4'b1100 : 4'b0011;
				default:   byteenable = 4'b1111;
			endcase
		end
	end

	// store data copied to every lane, enables pick the live one
	always_comb begin
		case (access_size)
			SIZE_BYTE: store_word = {4{rt_data[7:0]}};
			SIZE_HALF: store_word = {2{rt_data[15:0]}};
			default:   store_word = rt_data;
		endcase
	end

	assign writedata = (data_phase && mem_write) ? store_word : '0;

	// shift the addressed lanes down
	assign load_byte = readdata[8*byte_offset +: 8];
	assign load_half = byte_offset[1] ? readdata[31:16] : readdata[15:0];

	always_comb begin
		case (access_size)
			SIZE_BYTE: load_data = {{24{~load_unsigned & load_byte[7]}}, load_byte};
			SIZE_HALF: load_data = {{16{~load_unsigned & load_half[15]}}, load_half};
			default:   load_data = readdata;
		endcase
	end

endmodule

`default_nettype wire

/* hw/control_unit.sv */
// instruction decoder
// opcode and funct to ALU, register, memory and branch controls

`timescale 1ns/1ps
`default_nettype none

module control_unit
	import mips_cpu_pkg::*;
(
	input  word_t        instr,
	output alu_op_t      alu_op,
	output logic         alu_src_imm,
	output logic         imm_zero_extend,
	output logic         reg_write,
	output logic         dest_is_rd,
	output logic         mem_read,
	output logic         mem_write,
	output access_size_t access_size,
	output logic         load_unsigned,
	output logic         branch_eq,
	output logic         branch_ne,
	output logic         jump_reg
);

	opcode_t opcode;
	funct_t  funct;

	assign opcode = opcode_t'(instr[31:26]);
	assign funct  = funct_t'(instr[5:0]);

	always_comb begin
		// defaults give a no-op
		alu_op          = ALU_ADD;
		alu_src_imm     = 1'b0;
		imm_zero_extend = 1'b0;
		reg_write       = 1'b0;
		dest_is_rd      = 1'b0;
		mem_read        = 1'b0;
		mem_write       = 1'b0;
		access_size     = SIZE_WORD;
		load_unsigned   = 1'b0;
		branch_eq       = 1'b0;
		branch_ne       = 1'b0;
		jump_reg        = 1'b0;

		case (opcode)
			OP_SPECIAL: begin
				reg_write  = 1'b1;
				dest_is_rd = 1'b1;
				case (funct)
					FN_ADDU: alu_op = ALU_ADD;
					FN_SUBU: alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_XOR:  alu_op = ALU_XOR;
					FN_SLT:  alu_op = ALU_SLT;
					FN_SLL:  alu_op = ALU_SLL;
					FN_SRL:  alu_op = ALU_SRL;
					FN_JR: begin
						reg_write = 1'b0;
						jump_reg  = 1'b1;
					end
					default: reg_write = 1'b0;
				endcase
			end
			OP_ADDIU, OP_ANDI, OP_ORI, OP_LUI: begin
				reg_write       = 1'b1;
				alu_src_imm     = 1'b1;
				imm_zero_extend = (opcode == OP_ANDI) || (opcode == OP_ORI);
				case (opcode)
					OP_ANDI: alu_op = ALU_AND;
					OP_ORI:  alu_op = ALU_OR;
					OP_LUI:  alu_op = ALU_LUI;
					default: alu_op = ALU_ADD;
				endcase
			end
			OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
				reg_write     = 1'b1;
				alu_src_imm   = 1'b1;
				mem_read      = 1'b1;
				load_unsigned = (opcode == OP_LBU) || (opcode == OP_LHU);
				if (opcode == OP_LB || opcode == OP_LBU) begin
					access_size = SIZE_BYTE;
				end else if (opcode == OP_LH || opcode == OP_LHU) begin
					access_size = SIZE_HALF;
				end
			end
			OP_SB, OP_SH, OP_SW: begin
				alu_src_imm = 1'b1;
				mem_write   = 1'b1;
				if (opcode == OP_SB) begin
					access_size = SIZE_BYTE;
				end else if (opcode == OP_SH) begin
					access_size = SIZE_HALF;
				end
			end
			OP_BEQ: branch_eq = 1'b1;
			OP_BNE: branch_ne = 1'b1;
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

/* hw/register_file.sv */
// general purpose register file
// destination select, writeback mux and v0 tap

`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module register_file
	import mips_cpu_pkg::*;
(
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic commit,
	input  word_t     instr,
	input  wire logic reg_write,
	input  wire logic dest_is_rd,
	input  wire logic mem_read,
	input  word_t     alu_result,
	input  word_t     load_data,
	output word_t     rs_data,
	output word_t     rt_data,
	output word_t     register_v0
);

	word_t     regs [`CPU_REG_COUNT];
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	reg_addr_t dest;
	word_t     wdata;

	assign rs    = instr[25:21];
	assign rt    = instr[20:16];
	assign rd    = instr[15:11];
	assign dest  = dest_is_rd ? rd : rt;
	assign wdata = mem_read ? load_data : alu_result;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (commit && reg_write && dest != '0) begin
			// r0 stays zero
			regs[dest] <= wdata;
		end
	end

	assign rs_data     = regs[rs];
	assign rt_data     = regs[rt];
	assign register_v0 = regs[`CPU_REG_V0];

endmodule

`default_nettype wire

/* hw/execute_alu.sv */
// ALU with operand selection
// immediate extension, shift amount from the instruction

`timescale 1ns/1ps
`default_nettype none

module execute_alu
	import mips_cpu_pkg::*;
(
	input  word_t     instr,
	input  word_t     rs_data,
	input  word_t     rt_data,
	input  alu_op_t   alu_op,
	input  wire logic alu_src_imm,
	input  wire logic imm_zero_extend,
	output word_t     alu_result
);

	word_t      imm_ext;
	word_t      op_b;
	logic [4:0] shamt;

	assign imm_ext = imm_zero_extend ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
	assign op_b    = alu_src_imm ? imm_ext : rt_data;
	assign shamt   = instr[10:6];

	always_comb begin
		case (alu_op)
			ALU_ADD: alu_result = rs_data + op_b;
			ALU_SUB: alu_result = rs_data - op_b;
			ALU_AND: alu_result = rs_data & op_b;
			ALU_OR:  alu_result = rs_data | op_b;
			ALU_XOR: alu_result = rs_data ^ op_b;
			ALU_SLT: alu_result = {31'b0, $signed(rs_data) < $signed(op_b)};
			// shifts act on rt
			ALU_SLL: alu_result = op_b << shamt;
			ALU_SRL: alu_result = op_b >> shamt;
			ALU_LUI: alu_result = {op_b[15:0], 16'h0000};
			default: alu_result = '0;
		endcase
	end

endmodule

`default_nettype wire

/* hw/program_counter.sv */
// program counter with branch and jr resolution
// halts when the address reaches zero

`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module program_counter
	import mips_cpu_pkg::*;
(
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic commit,
	input  word_t     instr,
	input  word_t     rs_data,
	input  word_t     rt_data,
	input  wire logic branch_eq,
	input  wire logic branch_ne,
	input  wire logic jump_reg,
	output word_t     pc,
	output logic      halted
);

	word_t pc_plus4;
	word_t branch_target;
	word_t pc_next;
	logic  operands_equal;
	logic  taken;

	assign pc_plus4       = pc + 32'd4;
	assign branch_target  = pc_plus4 + {{14{instr[15]}}, instr[15:0], 2'b00};
	assign operands_equal = (rs_data == rt_data);
	assign taken          = (branch_eq & operands_equal) | (branch_ne & ~operands_equal);

	// no delay slot
	assign pc_next = jump_reg ? rs_data : (taken ? branch_target : pc_plus4);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= `CPU_RESET_VECTOR;
		end else if (commit) begin
			pc <= pc_next;
		end
	end

	assign halted = (pc == '0);

endmodule

`default_nettype wire

/* hw/mips_cpu_bus.sv */
// top level of the MIPS bus CPU
// ties sequencer, decoder, register file, ALU, PC and lane logic to the memory port

`timescale 1ns/1ps
`default_nettype none

module mips_cpu_bus (
	input  wire logic                clk,
	input  wire logic                reset,
	output logic                     active,
	output mips_cpu_pkg::word_t      register_v0,

	// avalon master
	output mips_cpu_pkg::word_t      address,
	output logic                     write,
	output logic                     read,
	input  wire logic                waitrequest,
	output mips_cpu_pkg::word_t      writedata,
	output logic [3:0]               byteenable,
	input  mips_cpu_pkg::word_t      readdata
);

	mips_cpu_pkg::word_t        instr;
	mips_cpu_pkg::word_t        pc;
	mips_cpu_pkg::word_t        alu_result;
	mips_cpu_pkg::word_t        rs_data;
	mips_cpu_pkg::word_t        rt_data;
	mips_cpu_pkg::word_t        load_data;
	mips_cpu_pkg::alu_op_t      alu_op;
	mips_cpu_pkg::access_size_t access_size;
	logic alu_src_imm;
	logic imm_zero_extend;
	logic reg_write;
	logic dest_is_rd;
	logic mem_read;
	logic mem_write;
	logic load_unsigned;
	logic branch_eq;
	logic branch_ne;
	logic jump_reg;
	logic data_phase;
	logic commit;
	logic halted;

	assign active = ~halted;

	bus_sequencer u_bus_sequencer (
		.clk        (clk),
		.reset      (reset),
		.waitrequest(waitrequest),
		.readdata   (readdata),
		.pc         (pc),
		.alu_result (alu_result),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.halted     (halted),
		.instr      (instr),
		.read       (read),
		.write      (write),
		.address    (address),
		.data_phase (data_phase),
		.commit     (commit)
	);

	control_unit u_control_unit (
		.instr          (instr),
		.alu_op         (alu_op),
		.alu_src_imm    (alu_src_imm),
		.imm_zero_extend(imm_zero_extend),
		.reg_write      (reg_write),
		.dest_is_rd     (dest_is_rd),
		.mem_read       (mem_read),
		.mem_write      (mem_write),
		.access_size    (access_size),
		.load_unsigned  (load_unsigned),
		.branch_eq      (branch_eq),
		.branch_ne      (branch_ne),
		.jump_reg       (jump_reg)
	);

	register_file u_register_file (
		.clk        (clk),
		.reset      (reset),
		.commit     (commit),
		.instr      (instr),
		.reg_write  (reg_write),
		.dest_is_rd (dest_is_rd),
		.mem_read   (mem_read),
		.alu_result (alu_result),
		.load_data  (load_data),
		.rs_data    (rs_data),
		.rt_data    (rt_data),
		.register_v0(register_v0)
	);

	execute_alu u_execute_alu (
		.instr          (instr),
		.rs_data        (rs_data),
		.rt_data        (rt_data),
		.alu_op         (alu_op),
		.alu_src_imm    (alu_src_imm),
		.imm_zero_extend(imm_zero_extend),
		.alu_result     (alu_result)
	);

	program_counter u_program_counter (
		.clk      (clk),
		.reset    (reset),
		.commit   (commit),
		.instr    (instr),
		.rs_data  (rs_data),
		.rt_data  (rt_data),
		.branch_eq(branch_eq),
		.branch_ne(branch_ne),
		.jump_reg (jump_reg),
		.pc       (pc),
		.halted   (halted)
	);

	byte_lane_unit u_byte_lane_unit (
		.data_phase   (data_phase),
		.mem_write    (mem_write),
		.access_size  (access_size),
		.load_unsigned(load_unsigned),
		.byte_offset  (alu_result[1:0]),
		.rt_data      (rt_data),
		.readdata     (readdata),
		.byteenable   (byteenable),
		.writedata    (writedata),
		.load_data    (load_data)
	);

endmodule

`default_nettype wire

/* bench/bus_checker.sv */
// result checker for the MIPS bus CPU
// shadows stores to address 1000 and compares v0 and that word at halt

`timescale 1ns/1ps
`default_nettype none

module bus_checker
	import mips_cpu_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       reset,
	input  wire logic       active,
	input  wire logic       read,
	input  wire logic       write,
	input  wire logic       waitrequest,
	input  word_t           address,
	input  word_t           writedata,
	input  wire logic [3:0] byteenable,
	input  word_t           register_v0,
	input  int              case_index,
	input  word_t           expected_v0,
	input  word_t           expected_word,
	output int              cases_passed,
	output int              cases_failed,
	output int              error_count
);

	localparam word_t CHECK_ADDR = 32'h0000_1000;

	word_t shadow_word;
	logic  reported;
	int    pass_total = 0;
	int    fail_total = 0;
	int    error_total = 0;
	int    mismatches;

	assign cases_passed = pass_total;
	assign cases_failed = fail_total;
	assign error_count  = error_total;

	function automatic word_t merge_lanes(input word_t old_word, input word_t data,
		input logic [3:0] enables);
		word_t merged;
		merged = old_word;
		for (int i = 0; i < 4; i++) begin
			if (enables[i]) begin
				merged[8*i +: 8] = data[8*i +: 8];
			end
		end
		return merged;
	endfunction

	always @(posedge clk or posedge reset) begin
		if (reset) begin
			shadow_word <= '0;
			reported    <= 1'b0;
		end else begin
			if ((read || write) && address[1:0] != 2'b00) begin
				$display("case %0d: bus address %h is not word aligned", case_index, address);
				error_total++;
			end
			// completed write to the watched word
			if (write && !waitrequest && address == CHECK_ADDR) begin
				shadow_word <= merge_lanes(shadow_word, writedata, byteenable);
			end
			if (!active && (read || write)) begin
				$display("case %0d: bus transfer issued after halt", case_index);
				error_total++;
			end
			if (!active && !reported) begin
				mismatches = 0;
				if (register_v0 !== expected_v0) begin
					$display("MISMATCH case %0d register_v0 got %h expected %h",
						case_index, register_v0, expected_v0);
					mismatches++;
				end
				if (shadow_word !== expected_word) begin
					$display("MISMATCH case %0d mem[00001000] got %h expected %h",
						case_index, shadow_word, expected_word);
					mismatches++;
				end
				error_total += mismatches;
				if (mismatches == 0) begin
					pass_total++;
					$display("case %0d passed: v0 %h, word %h", case_index, register_v0, shadow_word);
				end else begin
					fail_total++;
					$display("case %0d failed", case_index);
				end
				reported <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* bench/mips_cpu_bus_tb.sv */
// testbench top for the MIPS bus CPU
// clock, reset, waitrequest memory model, case loading and timeout

`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module mips_cpu_bus_tb
	import mips_cpu_pkg::*;
;

	localparam int NUM_CASES     = 7;
	localparam int PROGRAM_WORDS = 8;
	localparam int CASE_WORDS    = PROGRAM_WORDS + 2;
	localparam int CYCLE_LIMIT   = NUM_CASES * PROGRAM_WORDS * 20;

	logic       clk;
	logic       reset;
	logic       active;
	word_t      register_v0;
	word_t      address;
	logic       write;
	logic       read;
	logic       waitrequest = 1'b1;
	word_t      writedata;
	logic [3:0] byteenable;
	word_t      readdata = '0;

	word_t case_words [NUM_CASES * CASE_WORDS];
	word_t mem [word_t];
	int    case_index = 0;
	word_t expected_v0 = '0;
	word_t expected_word = '0;
	int    cases_passed;
	int    cases_failed;
	int    error_count;

	int    seed = 20;
	int    stall;
	int    wait_left = 0;
	logic  busy = 1'b0;
	int    cycle_count = 0;

	mips_cpu_bus u_mips_cpu_bus (
		.clk        (clk),
		.reset      (reset),
		.active     (active),
		.register_v0(register_v0),
		.address    (address),
		.write      (write),
		.read       (read),
		.waitrequest(waitrequest),
		.writedata  (writedata),
		.byteenable (byteenable),
		.readdata   (readdata)
	);

	bus_checker u_bus_checker (
		.clk          (clk),
		.reset        (reset),
		.active       (active),
		.read         (read),
		.write        (write),
		.waitrequest  (waitrequest),
		.address      (address),
		.writedata    (writedata),
		.byteenable   (byteenable),
		.register_v0  (register_v0),
		.case_index   (case_index),
		.expected_v0  (expected_v0),
		.expected_word(expected_word),
		.cases_passed (cases_passed),
		.cases_failed (cases_failed),
		.error_count  (error_count)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// unwritten locations read as zero
	function automatic word_t read_memory(input word_t addr);
		return mem.exists(addr) ? mem[addr] : '0;
	endfunction

	task automatic write_lanes(input word_t addr, input word_t data, input logic [3:0] enables);
		word_t merged;
		merged = read_memory(addr);
		for (int i = 0; i < 4; i++) begin
			if (enables[i]) begin
				merged[8*i +: 8] = data[8*i +: 8];
			end
		end
		mem[addr] = merged;
	endtask

	task automatic load_case(input int index);
		int base;
		base = index * CASE_WORDS;
		mem.delete();
		for (int i = 0; i < PROGRAM_WORDS; i++) begin
			mem[word_t'(`CPU_RESET_VECTOR + 4 * i)] = case_words[base + i];
		end
		case_index    = index;
		expected_v0   = case_words[base + PROGRAM_WORDS];
		expected_word = case_words[base + PROGRAM_WORDS + 1];
	endtask

	// memory model, first cycle of a transfer always stalls, then 0 to 3 more
	always @(posedge clk) begin
		if (reset) begin
			waitrequest <= 1'b1;
			busy        <= 1'b0;
		end else if (!waitrequest) begin
			// transfer completes in this cycle
			if (write) begin
				write_lanes(address, writedata, byteenable);
			end
			waitrequest <= 1'b1;
			busy        <= 1'b0;
		end else if (read || write) begin
			if (busy) begin
				stall = wait_left;
			end else begin
				stall = $unsigned($random(seed)) % 4;
			end
			busy <= 1'b1;
			if (stall == 0) begin
				waitrequest <= 1'b0;
				readdata    <= read_memory(address);
			end else begin
				wait_left <= stall - 1;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: case %0d did not halt within %0d cycles", case_index, CYCLE_LIMIT);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	initial begin
		reset = 1'b1;
		$readmemh("bench/cpu_cases.mem", case_words);
		for (int c = 0; c < NUM_CASES; c++) begin
			@(posedge clk);
			reset <= 1'b1;
			load_case(c);
			repeat (4) @(posedge clk);
			reset <= 1'b0;
			// run until the program jumps to address zero
			while (active) begin
				@(posedge clk);
			end
			// a few idle cycles so stray transfers after halt get seen
			repeat (3) @(posedge clk);
		end
		$display("cases %0d, passed %0d, failed %0d, errors %0d",
			NUM_CASES, cases_passed, cases_failed, error_count);
		if (cases_passed == NUM_CASES && cases_failed == 0 && error_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* bench/cpu_cases.mem */
// per case: eight instruction words loaded at the reset vector,
// then expected register_v0 and expected word at address 1000
//
// case 0: lui+ori t0, addiu t1, sll t2, subu t3, slt t1, addu v0, jr zero
3C081234 35085678 24090100 00095100 010A5823 0168482A 01691021 00000008
12344679 00000000
//
// case 1: sb at offsets 0, 1, 2, 3 of word 1000
24080011 A0081000 24080022 A0081001 24080033 A0081002 A0081003 00000008
00000000 33332211
//
// case 2: sh at offsets 2 and 0, then sb of v0 at offset 1
24087BCD A4081002 3409BEEF A4091000 24020005 A0021001 00000000 00000008
00000005 7BCD05EF
//
// case 3: store 80F17F02, lb from offset 2, lbu from offset 3, xor into v0
3C0880F1 35087F02 AC081000 80091002 900A1003 00000000 012A1026 00000008
FFFFFF71 80F17F02
//
// case 4: store 80F17F02, lh and lhu of the upper half, xor into v0
3C0880F1 35087F02 AC081000 84091002 940A1002 012A1026 00000000 00000008
FFFF0000 80F17F02
//
// case 5: beq taken skips 0BAD, bne not taken adds 10, ori 1
24080003 24090003 11090001 24020BAD 15090001 24420010 34420001 00000008
00000011 00000000
//
// case 6: bne taken, beq not taken, sw v0, jr zero with no delay slot
24080001 15000001 24020BAD 11000001 24420020 AC021000 00000008 24020BAD
00000020 00000020

/* mips_cpu_bus.f */
+incdir+include
hw/mips_cpu_pkg.sv
hw/bus_sequencer.sv
hw/byte_lane_unit.sv
hw/control_unit.sv
hw/register_file.sv
hw/execute_alu.sv
hw/program_counter.sv
hw/mips_cpu_bus.sv
bench/bus_checker.sv
bench/mips_cpu_bus_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = mips_cpu_bus_tb
FILELIST  = mips_cpu_bus.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
